// ==== codec_cfg.f ====
logic/codec_cfg_pkg.sv
logic/i2c_xfer_if.sv
logic/i2c_tick_gen.sv
logic/codec_init_seq.sv
logic/i2c_write_master.sv
logic/codec_cfg_top.sv
sim/tb_clk_gen.sv
sim/i2c_slave_model.sv
sim/codec_cfg_tb.sv

// ==== logic/codec_cfg_pkg.sv ====
package codec_cfg_pkg;

        // ------------------------------------------------------------------
        // Word and frame types
        // ------------------------------------------------------------------

        // Codec register word, 7-bit register address over 9-bit value
        typedef logic [15:0] cfg_word_t;

        // Bus frame, address byte followed by one register word
        typedef logic [23:0] i2c_frame_t;

        // Position in the start-up table
        typedef logic [3:0] reg_idx_t;

        // ------------------------------------------------------------------
        // Codec constants
        // ------------------------------------------------------------------

        // Write address byte of the audio codec
        localparam logic [7:0] CODEC_WR_ADDR = 8'h34;

        // Number of words written at start-up
        localparam int CFG_COUNT = 10;

        typedef cfg_word_t cfg_table_t [CFG_COUNT];

        // Start-up words, sent in this order
        localparam cfg_table_t CFG_TABLE = '{
                16'h001A,       // Line in left
                16'h021A,       // Line in right
                16'h047B,       // Headphone left
                16'h067B,       // Headphone right
                16'h08F8,       // Analog path
                16'h0A06,       // Digital path
                16'h0C00,       // Power on
                16'h0E42,       // Data format
                16'h107C,       // Sample control
                16'h1201        // Activate
        };

endpackage

// ==== logic/codec_cfg_top.sv ====
`timescale 1ns/10ps

module codec_cfg_top #(
        parameter int CLK_FREQ = 50_000_000,
        parameter int I2C_FREQ = 100_000
) (
        input  logic clk_i,
        input  logic rst_n_i,
        output logic scl_o,
        output logic sda_o,
        input  logic sda_i,
        output logic init_done_o
);

        // Four ticks per bus bit
        localparam int DIV_COUNT = CLK_FREQ / (4 * I2C_FREQ);

        logic tick;

        i2c_xfer_if xfer ();

        // ------------------------------------------------------------------
        // Quarter-bit timing
        // ------------------------------------------------------------------

        i2c_tick_gen #(
                .DIV_COUNT      (DIV_COUNT)
        ) u_tick_gen (
                .clk_i          (clk_i),
                .rst_n_i        (rst_n_i),
                .tick_o         (tick)
        );

        // Table walker
        codec_init_seq u_init_seq (
                .clk_i          (clk_i),
                .rst_n_i        (rst_n_i),
                .xfer           (xfer.seq_mp),
                .init_done_o    (init_done_o)
        );

        // Open-drain bus engine
        i2c_write_master u_write_master (
                .clk_i          (clk_i),
                .rst_n_i        (rst_n_i),
                .tick_i         (tick),
                .xfer           (xfer.mst_mp),
                .scl_o          (scl_o),
                .sda_o          (sda_o),
                .sda_i          (sda_i)
        );

endmodule

// ==== logic/codec_init_seq.sv ====
`timescale 1ns/10ps

module codec_init_seq (
        input  logic            clk_i,
        input  logic            rst_n_i,
        i2c_xfer_if.seq_mp      xfer,
        output logic            init_done_o
);

        typedef enum logic [1:0]
        {
                ISSUE,
                WAIT,
                DONE
        } seq_state_t;

        seq_state_t                     state;
        codec_cfg_pkg::reg_idx_t        idx;
        logic                           last_idx;

        // ------------------------------------------------------------------
        // Frame contents
        // ------------------------------------------------------------------

        // Index only moves on an acked done, so frame stays put meanwhile
        assign xfer.frame = {codec_cfg_pkg::CODEC_WR_ADDR, codec_cfg_pkg::CFG_TABLE[idx]};

        assign last_idx = (idx == codec_cfg_pkg::reg_idx_t'(codec_cfg_pkg::CFG_COUNT - 1));

        // Level flag, held until the next reset
        assign init_done_o = (state == DONE);

        // ------------------------------------------------------------------
        // Table walk
        // ------------------------------------------------------------------

        always_ff @(posedge clk_i or negedge rst_n_i)
        begin
                if (!rst_n_i)
                begin
                        state      <= ISSUE;
                        idx        <= '0;
                        xfer.start <= 1'b0;
                end
                else
                begin
                        // Start is a single pulse
                        xfer.start <= 1'b0;
                        case (state)
                        ISSUE:
                        begin
                                xfer.start <= 1'b1;
                                state      <= WAIT;
                        end
                        WAIT:
                        begin
                                if (xfer.done)
                                begin
                                        // No ack, same word again
                                        if (xfer.nack)
                                                state <= ISSUE;
                                        else if (last_idx)
                                                state <= DONE;
                                        else
                                        begin
                                                idx   <= idx + 1'b1;
                                                state <= ISSUE;
                                        end
                                end
                        end
                        DONE:
                        begin
                                state <= DONE;
                        end
                        default:
                        begin
                                state <= ISSUE;
                        end
                        endcase
                end
        end

        // Master only reports back on an outstanding request
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
                xfer.done |-> ((state == WAIT) && !xfer.start));

endmodule

// ==== logic/i2c_tick_gen.sv ====
`timescale 1ns/10ps

module i2c_tick_gen #(
        parameter int DIV_COUNT = 4
) (
        input  logic clk_i,
        input  logic rst_n_i,
        output logic tick_o
);

        // Counter needs at least one bit
        localparam int CNT_W = (DIV_COUNT > 1) ? $clog2(DIV_COUNT) : 1;

        logic [CNT_W-1:0]       cnt;
        logic                   wrap;

        // Last cycle of a quarter-bit period
        assign wrap = (cnt == CNT_W'(DIV_COUNT - 1));

        always_ff @(posedge clk_i or negedge rst_n_i)
        begin
                if (!rst_n_i)
                begin
                        cnt    <= '0;
                        tick_o <= 1'b0;
                end
                else
                begin
                        // Strobe follows the wrap by one register stage
                        tick_o <= wrap;
                        if (wrap)
                                cnt <= '0;
                        else
                                cnt <= cnt + 1'b1;
                end
        end

        // Ticks are isolated pulses once the divider is real
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
                ((DIV_COUNT > 1) && tick_o) |=> !tick_o);

endmodule

// ==== logic/i2c_write_master.sv ====
`timescale 1ns/10ps

module i2c_write_master (
        input  logic            clk_i,
        input  logic            rst_n_i,
        input  logic            tick_i,
        i2c_xfer_if.mst_mp      xfer,
        output logic            scl_o,
        output logic            sda_o,
        input  logic            sda_i
);

        typedef enum logic [2:0]
        {
                IDLE,
                START,
                BIT,
                ACK,
                STOP
        } mst_state_t;

        mst_state_t                     state;
        logic [1:0]                     qtr;
        logic [4:0]                     bit_cnt;
        logic                           nack_q;
        codec_cfg_pkg::i2c_frame_t      shreg;

        // Sticky over all three ack slots
        assign xfer.nack = nack_q;

        // ------------------------------------------------------------------
        // Frame shifter, MSB first
        // ------------------------------------------------------------------

        always_ff @(posedge clk_i)
        begin
                if ((state == IDLE) && xfer.start)
                        shreg <= xfer.frame;
                else if (tick_i && (state == BIT) && (qtr == 2'd3))
                        shreg <= shreg << 1;
        end

        // ------------------------------------------------------------------
        // Bit engine, four quarters per phase
        // ------------------------------------------------------------------

        always_ff @(posedge clk_i or negedge rst_n_i)
        begin
                if (!rst_n_i)
                begin
                        state     <= IDLE;
                        qtr       <= '0;
                        bit_cnt   <= '0;
                        nack_q    <= 1'b0;
                        scl_o     <= 1'b1;
                        sda_o     <= 1'b1;
                        xfer.done <= 1'b0;
                end
                else
                begin
                        xfer.done <= 1'b0;
                        if (state == IDLE)
                        begin
                                // Accepted at once, waits for ticks from here
                                if (xfer.start)
                                begin
                                        state   <= START;
                                        qtr     <= '0;
                                        bit_cnt <= '0;
                                        nack_q  <= 1'b0;
                                end
                        end
                        else if (tick_i)
                        begin
                                qtr <= qtr + 1'b1;
                                case (state)
                                START:
                                begin
                                        // SDA falls with SCL high
                                        if (qtr == 2'd1)
                                                sda_o <= 1'b0;
                                        if (qtr == 2'd3)
                                        begin
                                                scl_o <= 1'b0;
                                                state <= BIT;
                                        end
                                end
                                BIT:
                                begin
                                        case (qtr)
                                        2'd0: sda_o <= shreg[23];
                                        2'd1: scl_o <= 1'b1;
                                        2'd3:
                                        begin
                                                scl_o   <= 1'b0;
                                                bit_cnt <= bit_cnt + 1'b1;
                                                // Byte boundary
                                                if (bit_cnt[2:0] == 3'd7)
                                                        state <= ACK;
                                        end
                                        default: ;
                                        endcase
                                end
                                ACK:
                                begin
                                        case (qtr)
                                        2'd0: sda_o <= 1'b1;
                                        2'd1: scl_o <= 1'b1;
                                        // Sample mid SCL high
                                        2'd2: nack_q <= nack_q | sda_i;
                                        default:
                                        begin
                                                scl_o <= 1'b0;
                                                if (bit_cnt == 5'd24)
                                                        state <= STOP;
                                                else
                                                        state <= BIT;
                                        end
                                        endcase
                                end
                                STOP:
                                begin
                                        case (qtr)
                                        2'd0: sda_o <= 1'b0;
                                        2'd1: scl_o <= 1'b1;
                                        // SDA rises with SCL high
                                        2'd2: sda_o <= 1'b1;
                                        default:
                                        begin
                                                xfer.done <= 1'b1;
                                                state     <= IDLE;
                                        end
                                        endcase
                                end
                                default:
                                begin
                                        state <= IDLE;
                                end
                                endcase
                        end
                end
        end

        // Data and ack slots keep SDA steady through SCL high
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
                (scl_o && $past(scl_o) && ((state == BIT) || (state == ACK)))
                |-> $stable(sda_o));

endmodule

// ==== logic/i2c_xfer_if.sv ====
`timescale 1ns/10ps

// Request and result lines between table walker and bus master
interface i2c_xfer_if;

        // One-cycle request pulse
        logic                           start;
        // Held stable from start until done
        codec_cfg_pkg::i2c_frame_t      frame;
        // One-cycle completion pulse
        logic                           done;
        // Any acknowledge slot read high, valid with done
        logic                           nack;

        // Table walker side
        modport seq_mp (
                output start,
                output frame,
                input  done,
                input  nack
        );

        // Bus master side
        modport mst_mp (
                input  start,
                input  frame,
                output done,
                output nack
        );

endinterface

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps -f codec_cfg.f \
        --top-module codec_cfg_tb -Mdir obj_dir -o codec_cfg_sim \
        && ./obj_dir/codec_cfg_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim/codec_cfg_tb.sv ====
`timescale 1ns/10ps

module codec_cfg_tb;

        // 125 MHz clock, divider of 4
        localparam int CLK_FREQ       = 125_000_000;
        localparam int I2C_FREQ       = 7_812_500;
        localparam int TIMEOUT_CYCLES = 3 * codec_cfg_pkg::CFG_COUNT * 29 * 4 * 4;
        localparam int QUIET_CYCLES   = 64;
        localparam codec_cfg_pkg::reg_idx_t END_IDX =
                codec_cfg_pkg::reg_idx_t'(codec_cfg_pkg::CFG_COUNT);

        logic                           clk;
        logic                           rst_n;
        logic                           scl;
        logic                           sda_m;
        logic                           sda_bus;
        logic                           init_done;
        logic                           frame_stb;
        logic                           frame_nack;
        logic                           proto_err;
        codec_cfg_pkg::i2c_frame_t      frame;
        // Next table word the codec expects
        codec_cfg_pkg::reg_idx_t        exp_idx = '0;
        logic                           bus_seen = 1'b0;
        int                             cycle_cnt = 0;

        tb_clk_gen u_clk_gen (
                .clk_o          (clk),
                .rst_n_o        (rst_n)
        );

        codec_cfg_top #(
                .CLK_FREQ       (CLK_FREQ),
                .I2C_FREQ       (I2C_FREQ)
        ) UUT (
                .clk_i          (clk),
                .rst_n_i        (rst_n),
                .scl_o          (scl),
                .sda_o          (sda_m),
                .sda_i          (sda_bus),
                .init_done_o    (init_done)
        );

        i2c_slave_model #(
                .SEED           (13002)
        ) u_slave (
                .clk_i          (clk),
                .rst_n_i        (rst_n),
                .scl_i          (scl),
                .sda_m_i        (sda_m),
                .sda_o          (sda_bus),
                .frame_stb_o    (frame_stb),
                .frame_o        (frame),
                .frame_nack_o   (frame_nack),
                .error_o        (proto_err)
        );

        task automatic stop_with_failure();
                $display("Checks failed");
                $fatal(1);
        endtask

        task automatic report_mismatch(input string name, input logic [31:0] got_v,
                                       input logic [31:0] exp_v);
                $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got_v, exp_v);
                stop_with_failure();
        endtask

        // ------------------------------------------------------------------
        // Checks
        // ------------------------------------------------------------------

        // Bus idle until the first start condition
        always @(posedge clk)
        begin
                if (rst_n && !bus_seen)
                begin
                        if (scl && !sda_m)
                                bus_seen = 1'b1;
                        else
                        begin
                                assert ({scl, sda_m, init_done} == 3'b110)
                                else
                                        report_mismatch("scl_o sda_o init_done_o",
                                                        32'({scl, sda_m, init_done}), 32'h6);
                        end
                end
        end

        // Scoreboard per decoded frame
        always @(posedge clk)
        begin
                if (frame_stb)
                begin
                        assert (frame[23:16] == codec_cfg_pkg::CODEC_WR_ADDR)
                        else
                                report_mismatch("frame address byte", 32'(frame[23:16]),
                                                32'(codec_cfg_pkg::CODEC_WR_ADDR));
                        assert (!init_done)
                        else
                                report_mismatch("init_done_o", 32'(init_done), 32'h0);
                        assert (exp_idx != END_IDX)
                        else
                        begin
                                $display("Frame sent after the last word was acknowledged");
                                stop_with_failure();
                        end
                        // Refused frame repeats, so index holds
                        assert (frame[15:0] == codec_cfg_pkg::CFG_TABLE[exp_idx])
                        else
                                report_mismatch("frame word", 32'(frame[15:0]),
                                                32'(codec_cfg_pkg::CFG_TABLE[exp_idx]));
                        if (!frame_nack)
                                exp_idx <= exp_idx + 1'b1;
                end
        end

        always @(posedge proto_err)
                stop_with_failure();

        // Run limit
        always @(posedge clk)
        begin
                cycle_cnt <= cycle_cnt + 1;
                if (cycle_cnt == TIMEOUT_CYCLES)
                begin
                        $display("Timeout, configuration not complete after %0d cycles",
                                 cycle_cnt);
                        stop_with_failure();
                end
        end

        // Completion, then a quiet bus
        initial
        begin : end_of_run
                logic quiet;
                quiet = 1'b1;
                @(posedge init_done);
                assert (exp_idx == END_IDX)
                else
                        report_mismatch("acknowledged word count", 32'(exp_idx), 32'(END_IDX));
                repeat (QUIET_CYCLES)
                begin
                        @(posedge clk);
                        if (!(scl && sda_m && init_done))
                                quiet = 1'b0;
                end
                if (quiet)
                begin
                        $display("All checks passed");
                        $finish;
                end
                else
                begin
                        $display("Bus activity or init_done_o drop after configuration");
                        stop_with_failure();
                end
        end

endmodule

// ==== sim/i2c_slave_model.sv ====
`timescale 1ns/10ps

module i2c_slave_model #(
        parameter int SEED = 1
) (
        input  logic                            clk_i,
        input  logic                            rst_n_i,
        input  logic                            scl_i,
        input  logic                            sda_m_i,
        output logic                            sda_o,
        output logic                            frame_stb_o,
        output codec_cfg_pkg::i2c_frame_t       frame_o,
        output logic                            frame_nack_o,
        output logic                            error_o
);

        // Resolved line, and own pull-down where 0 pulls low
        logic           bus = 1'b1;
        logic           drive = 1'b1;
        logic           err = 1'b0;
        logic           seeded = 1'b0;
        logic           scl_q;
        logic           sda_q;
        logic           in_frame;
        logic           in_ack;
        logic           nack_sel;
        logic [4:0]     nbits;

        assign sda_o   = bus;
        assign error_o = err;

        // Wired AND, settles 1 ns after the edge
        always @(posedge clk_i)
        begin
                #1;
                bus = sda_m_i & drive;
        end

        task automatic protocol_error(input string what);
                $display("Protocol error: %s", what);
                err = 1'b1;
        endtask

        // ------------------------------------------------------------------
        // Frame decoder
        // ------------------------------------------------------------------

        always @(posedge clk_i or negedge rst_n_i)
        begin
                if (!rst_n_i)
                begin
                        drive        <= 1'b1;
                        scl_q        <= 1'b1;
                        sda_q        <= 1'b1;
                        in_frame     <= 1'b0;
                        in_ack       <= 1'b0;
                        nack_sel     <= 1'b0;
                        nbits        <= '0;
                        frame_o      <= '0;
                        frame_stb_o  <= 1'b0;
                        frame_nack_o <= 1'b0;
                end
                else
                begin
                        // One seed for the whole run
                        if (!seeded)
                        begin
                                void'($urandom(SEED));
                                seeded = 1'b1;
                        end
                        frame_stb_o <= 1'b0;
                        scl_q       <= scl_i;
                        sda_q       <= bus;
                        // SDA moving with SCL high, start or stop only
                        if (scl_i && scl_q && (bus != sda_q))
                        begin
                                if (!bus)
                                begin
                                        assert (!in_frame)
                                        else
                                                protocol_error("start condition inside a frame");
                                        in_frame <= 1'b1;
                                        in_ack   <= 1'b0;
                                        nbits    <= '0;
                                        // Address refused one time in four
                                        nack_sel <= (($urandom % 32'd4) == 32'd0);
                                end
                                else
                                begin
                                        assert (in_frame && !in_ack && (nbits == 5'd24))
                                        else
                                                protocol_error("stop condition out of place");
                                        in_frame     <= 1'b0;
                                        frame_stb_o  <= 1'b1;
                                        frame_nack_o <= nack_sel;
                                end
                        end
                        else if (in_frame && scl_i && !scl_q && !in_ack
                                 && (nbits != 5'd24))
                        begin
                                // Data bit on rising SCL, MSB first
                                // Full frame means the next rise belongs to the stop
                                frame_o <= {frame_o[22:0], bus};
                                nbits   <= nbits + 1'b1;
                        end
                        else if (in_frame && !scl_i && scl_q)
                        begin
                                if (in_ack)
                                begin
                                        in_ack <= 1'b0;
                                        drive  <= 1'b1;
                                end
                                else if ((nbits != 5'd0) && (nbits[2:0] == 3'd0))
                                begin
                                        // Refused address leaves all three slots high
                                        in_ack <= 1'b1;
                                        drive  <= nack_sel;
                                end
                        end
                end
        end

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen #(
        parameter int HALF_PERIOD_NS = 4,
        parameter int RST_CYCLES     = 2
) (
        output logic clk_o,
        output logic rst_n_o
);

        // Free-running clock, 8 ns period
        initial
        begin
                clk_o = 1'b0;
                forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
        end

        // Reset released just after the second rising edge
        initial
        begin
                rst_n_o = 1'b0;
                repeat (RST_CYCLES) @(posedge clk_o);
                #1 rst_n_o = 1'b1;
        end

endmodule
